// ==== rtl/kbd_pkg.sv ====
package kbd_pkg;

    // ==================================================
    // Z88 key matrix geometry
    // ==================================================

    localparam int matrix_bits = 64;             // A8..A15 x 8 rows
    localparam int matrix_cols = 8;              // Address lines A8..A15

    // ==================================================
    // PS/2 prefix bytes
    // ==================================================

    localparam logic [3:0] prefix_ext_nib = 4'hE; // E0 / E1
    localparam logic [3:0] prefix_brk_nib = 4'hF; // F0 upstroke

    // ==================================================
    // Decoded key event
    // ==================================================

    // Build view, as assembled from the prefix flags
    typedef struct packed {
        logic       brk;                         // Key released
        logic       ext;                         // Seen after E0
        logic [6:0] base;                        // Low 7 bits of make code
    } key_build_t;

    // Lookup view, ext folds into bit 7 of the code
    typedef struct packed {
        logic       brk;
        logic [7:0] code;                        // Matrix / display code
    } key_lookup_t;

    typedef union packed {
        key_build_t  build;
        key_lookup_t lookup;
    } key_event_u;

endpackage

// ==== rtl/board_pkg.sv ====
package board_pkg;

    // ==================================================
    // Board switches
    // ==================================================

    localparam int switch_count = 10;
    localparam int filter_depth = 5;             // Agreeing samples needed

    // ==================================================
    // Seven-segment codes, active low, gfedcba
    // ==================================================

    localparam logic [6:0] seg_patterns [16] = '{
        7'b1000000,                              // 0
        7'b1111001,                              // 1
        7'b0100100,                              // 2
        7'b0110000,                              // 3
        7'b0011001,                              // 4
        7'b0010010,                              // 5
        7'b0000010,                              // 6
        7'b1111000,                              // 7
        7'b0000000,                              // 8
        7'b0010000,                              // 9
        7'b0001000,                              // A
        7'b0000011,                              // b
        7'b1000110,                              // C
        7'b0100001,                              // d
        7'b0000110,                              // E
        7'b0001110                               // F
    };

endpackage

// ==== rtl/scan_prefix_decoder.sv ====
module scan_prefix_decoder (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  logic                scan_valid,
    input  logic [7:0]          scan_data,
    output logic                key_valid,
    output kbd_pkg::key_event_u key_event
);

    logic ext_flag;
    logic brk_flag;
    logic is_ext;
    logic is_brk;
    logic take_key;

    assign is_ext   = (scan_data[7:4] == kbd_pkg::prefix_ext_nib);
    assign is_brk   = (scan_data[7:4] == kbd_pkg::prefix_brk_nib);
    assign take_key = scan_valid & ~is_ext & ~is_brk;

    // ==================================================
    // Prefix flags and event strobe
    // ==================================================

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            ext_flag  <= 1'b0;
            brk_flag  <= 1'b0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= take_key;                // One cycle per key code
            if (scan_valid && is_ext) begin
                ext_flag <= 1'b1;
            end
            if (scan_valid && is_brk) begin
                brk_flag <= 1'b1;
            end
            if (take_key) begin
                ext_flag <= 1'b0;                 // Flags apply to one code only
                brk_flag <= 1'b0;
            end
        end
    end

    // Event payload, held until the next key code
    always_ff @(posedge CLOCK_50) begin
        if (take_key) begin
            key_event.build.brk  <= brk_flag;
            key_event.build.ext  <= ext_flag | scan_data[7];
            key_event.build.base <= scan_data[6:0];
        end
    end

endmodule

// ==== rtl/key_matrix.sv ====
module key_matrix (
    input  logic                               CLOCK_50,
    input  logic                               reset,
    input  logic                               key_valid,
    input  kbd_pkg::key_event_u                key_event,
    input  logic [kbd_pkg::matrix_cols-1:0]    col_select,
    output logic [kbd_pkg::matrix_bits-1:0]    kbd_matrix,
    output logic [7:0]                         column_view
);

    localparam int ROWS = kbd_pkg::matrix_bits / kbd_pkg::matrix_cols;

    logic [6:0] slot;                             // {hit, bit index}

    // Scan code to matrix position, bit = column * 8 + row
    function automatic logic [6:0] key_slot(input logic [7:0] code);
        case (code)
            8'h3E: key_slot = {1'b1, 6'd0};       // A8: 8
            8'h3D: key_slot = {1'b1, 6'd1};       // 7
            8'h31: key_slot = {1'b1, 6'd2};       // N
            8'h33: key_slot = {1'b1, 6'd3};       // H
            8'h35: key_slot = {1'b1, 6'd4};       // Y
            8'h36: key_slot = {1'b1, 6'd5};       // 6
            8'h5A: key_slot = {1'b1, 6'd6};       // Enter
            8'h66: key_slot = {1'b1, 6'd7};       // Del
            8'h43: key_slot = {1'b1, 6'd8};       // A9: I
            8'h3C: key_slot = {1'b1, 6'd9};       // U
            8'h32: key_slot = {1'b1, 6'd10};      // B
            8'h34: key_slot = {1'b1, 6'd11};      // G
            8'h2C: key_slot = {1'b1, 6'd12};      // T
            8'h2E: key_slot = {1'b1, 6'd13};      // 5
            8'hF5: key_slot = {1'b1, 6'd14};      // Up
            8'h5D: key_slot = {1'b1, 6'd15};      // Backslash
            8'h44: key_slot = {1'b1, 6'd16};      // A10: O
            8'h3B: key_slot = {1'b1, 6'd17};      // J
            8'h2A: key_slot = {1'b1, 6'd18};      // V
            8'h2B: key_slot = {1'b1, 6'd19};      // F
            8'h2D: key_slot = {1'b1, 6'd20};      // R
            8'h25: key_slot = {1'b1, 6'd21};      // 4
            8'hF2: key_slot = {1'b1, 6'd22};      // Down
            8'h55: key_slot = {1'b1, 6'd23};      // =
            8'h46: key_slot = {1'b1, 6'd24};      // A11: 9
            8'h42: key_slot = {1'b1, 6'd25};      // K
            8'h21: key_slot = {1'b1, 6'd26};      // C
            8'h23: key_slot = {1'b1, 6'd27};      // D
            8'h24: key_slot = {1'b1, 6'd28};      // E
            8'h26: key_slot = {1'b1, 6'd29};      // 3
            8'hF4: key_slot = {1'b1, 6'd30};      // Right
            8'h4E: key_slot = {1'b1, 6'd31};      // -
            8'h4D: key_slot = {1'b1, 6'd32};      // A12: P
            8'h3A: key_slot = {1'b1, 6'd33};      // M
            8'h22: key_slot = {1'b1, 6'd34};      // X
            8'h1B: key_slot = {1'b1, 6'd35};      // S
            8'h1D: key_slot = {1'b1, 6'd36};      // W
            8'h1E: key_slot = {1'b1, 6'd37};      // 2
            8'hEB: key_slot = {1'b1, 6'd38};      // Left
            8'h5B: key_slot = {1'b1, 6'd39};      // ]
            8'h45: key_slot = {1'b1, 6'd40};      // A13: 0
            8'h4B: key_slot = {1'b1, 6'd41};      // L
            8'h1A: key_slot = {1'b1, 6'd42};      // Z
            8'h1C: key_slot = {1'b1, 6'd43};      // A
            8'h15: key_slot = {1'b1, 6'd44};      // Q
            8'h16: key_slot = {1'b1, 6'd45};      // 1
            8'h29: key_slot = {1'b1, 6'd46};      // Space
            8'h54: key_slot = {1'b1, 6'd47};      // [
            8'h52: key_slot = {1'b1, 6'd48};      // A14: quote
            8'h4C: key_slot = {1'b1, 6'd49};      // ;
            8'h41: key_slot = {1'b1, 6'd50};      // ,
            8'h04: key_slot = {1'b1, 6'd51};      // Menu on F3
            8'h14: key_slot = {1'b1, 6'd52};      // Diamond on left Ctrl
            8'h94: key_slot = {1'b1, 6'd52};      // Diamond on right Ctrl
            8'h0D: key_slot = {1'b1, 6'd53};      // Tab
            8'h12: key_slot = {1'b1, 6'd54};      // Left shift
            8'h05: key_slot = {1'b1, 6'd55};      // Help on F1
            8'h0E: key_slot = {1'b1, 6'd56};      // A15: pound
            8'h4A: key_slot = {1'b1, 6'd57};      // /
            8'h49: key_slot = {1'b1, 6'd58};      // .
            8'h58: key_slot = {1'b1, 6'd59};      // Caps lock
            8'h06: key_slot = {1'b1, 6'd60};      // Index on F2
            8'h76: key_slot = {1'b1, 6'd61};      // Esc
            8'h11: key_slot = {1'b1, 6'd62};      // Square on left Alt
            8'h91: key_slot = {1'b1, 6'd62};      // Square on right Alt
            8'h59: key_slot = {1'b1, 6'd63};      // Right shift
            default: key_slot = 7'd0;             // Not a Z88 key
        endcase
    endfunction

    assign slot = key_slot(key_event.lookup.code);

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            kbd_matrix <= '0;
        end else if (key_valid && slot[6]) begin
            kbd_matrix[slot[5:0]] <= ~key_event.lookup.brk;
        end
    end

    // ==================================================
    // Selected columns, ORed for the green LEDs
    // ==================================================

    always_comb begin
        column_view = '0;
        for (int c = 0; c < kbd_pkg::matrix_cols; c++) begin
            if (col_select[c]) begin
                column_view = column_view | kbd_matrix[c*ROWS +: ROWS];
            end
        end
    end

endmodule

// ==== rtl/switch_filter.sv ====
module switch_filter #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 5
) (
    input  logic             CLOCK_50,
    input  logic             reset,
    input  logic [WIDTH-1:0] raw,
    output logic [WIDTH-1:0] filtered
);

    localparam int STAGES = DEPTH + 2;            // Two for metastability

    logic [WIDTH-1:0] sync_q [STAGES];
    logic [WIDTH-1:0] all_one;
    logic [WIDTH-1:0] all_zero;

    // Agreement over the last DEPTH stages
    always_comb begin
        all_one  = '1;
        all_zero = '1;
        for (int s = 2; s < STAGES; s++) begin
            all_one  = all_one & sync_q[s];
            all_zero = all_zero & ~sync_q[s];
        end
    end

    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < STAGES; s++) begin
                sync_q[s] <= '0;
            end
            filtered <= '0;
        end else begin
            sync_q[0] <= raw;
            for (int s = 1; s < STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
            filtered <= (filtered | all_one) & ~all_zero; // Hold on disagreement
        end
    end

endmodule

// ==== rtl/hex_display.sv ====
module hex_display #(
    parameter int DIGITS = 2
) (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  logic                key_valid,
    input  kbd_pkg::key_event_u key_event,
    output logic [6:0]          hex0,
    output logic [6:0]          hex1
);

    logic [6:0] seg_q [DIGITS];

    // One digit per nibble of the lookup code, digit 0 is the low nibble
    always_ff @(posedge CLOCK_50 or posedge reset) begin
        if (reset) begin
            for (int d = 0; d < DIGITS; d++) begin
                seg_q[d] <= board_pkg::seg_patterns[0]; // Shows "0"
            end
        end else if (key_valid) begin
            for (int d = 0; d < DIGITS; d++) begin
                seg_q[d] <= board_pkg::seg_patterns[key_event.lookup.code[d*4 +: 4]];
            end
        end
    end

    assign hex0 = seg_q[0];
    assign hex1 = seg_q[1];

endmodule

// ==== rtl/z88_kbd_board_top.sv ====
module z88_kbd_board_top (
    input  logic                                CLOCK_50,
    input  logic                                reset,
    input  logic                                scan_valid,
    input  logic [7:0]                          scan_data,
    input  logic [board_pkg::switch_count-1:0]  sw,
    input  logic                                key_flap_n,
    output logic [kbd_pkg::matrix_bits-1:0]     kbd_matrix,
    output logic [6:0]                          hex0,
    output logic [6:0]                          hex1,
    output logic [8:0]                          ledr,
    output logic [7:0]                          ledg,
    output logic                                flap
);

    logic                               key_valid;
    kbd_pkg::key_event_u                key_event;
    logic [board_pkg::switch_count-1:0] sw_filtered;
    logic                               flap_filtered;
    logic [7:0]                         col_select;

    // ==================================================
    // Keyboard path
    // ==================================================

    scan_prefix_decoder u_decoder (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .scan_valid (scan_valid),
        .scan_data  (scan_data),
        .key_valid  (key_valid),
        .key_event  (key_event)
    );

    key_matrix u_matrix (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .key_valid   (key_valid),
        .key_event   (key_event),
        .col_select  (col_select),
        .kbd_matrix  (kbd_matrix),
        .column_view (ledg)
    );

    hex_display #(.DIGITS(2)) u_hex (
        .CLOCK_50  (CLOCK_50),
        .reset     (reset),
        .key_valid (key_valid),
        .key_event (key_event),
        .hex0      (hex0),
        .hex1      (hex1)
    );

    // ==================================================
    // Switches and flap key
    // ==================================================

    switch_filter #(
        .WIDTH (board_pkg::switch_count),
        .DEPTH (board_pkg::filter_depth)
    ) u_sw_filter (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .raw      (sw),
        .filtered (sw_filtered)
    );

    // Flap key is active low on the pin, filtered as active high
    switch_filter #(
        .WIDTH (1),
        .DEPTH (board_pkg::filter_depth)
    ) u_flap_filter (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .raw      (~key_flap_n),
        .filtered (flap_filtered)
    );

    assign flap       = flap_filtered;
    assign col_select = sw_filtered[7:0];         // SW0..SW7 pick A8..A15
    assign ledr       = {flap_filtered, sw_filtered[7:0]};

endmodule

// ==== verification/z88_kbd_board_props.sv ====
module z88_kbd_board_props (
    input logic       CLOCK_50,
    input logic       reset,
    input logic       scan_valid,
    input logic [7:0] scan_data,
    input logic       key_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic prefix_byte;

    assign prefix_byte = scan_valid &&
                         (scan_data[7:4] == 4'hE || scan_data[7:4] == 4'hF);

    // ==================================================
    // Decoder strobe rules
    // ==================================================

    // First clocked update after reset release must not raise an event
    quiet_after_reset: assert property (
        @(posedge CLOCK_50) $fell(reset) |=> !key_valid
    ) else $error("key_valid high in the cycle after reset release");

    strobe_needs_byte: assert property (
        @(posedge CLOCK_50) disable iff (reset) $rose(key_valid) |-> $past(scan_valid)
    ) else $error("key_valid rose without a byte taken the cycle before");

    // Prefix only arms the flags
    no_event_on_prefix: assert property (
        @(posedge CLOCK_50) disable iff (reset) prefix_byte |=> !key_valid
    ) else $error("key event followed a prefix byte");

endmodule

// ==== verification/tb_z88_kbd_board.sv ====
module tb_z88_kbd_board;
    timeunit 1ns;
    timeprecision 100ps;

    logic        CLOCK_50;
    logic        reset;
    logic        scan_valid;
    logic [7:0]  scan_data;
    logic [9:0]  sw;
    logic        key_flap_n;
    logic [63:0] kbd_matrix;
    logic [6:0]  hex0;
    logic [6:0]  hex1;
    logic [8:0]  ledr;
    logic [7:0]  ledg;
    logic        flap;
    logic [63:0] model;                           // Expected kbd_matrix
    int          errors;
    int          mark;                            // Errors at end of last test
    int          tests_run;
    integer      seed;

    // Entry i is matrix bit i, then the right Ctrl and right Alt aliases
    localparam logic [7:0] key_codes [66] = '{
        8'h3E, 8'h3D, 8'h31, 8'h33, 8'h35, 8'h36, 8'h5A, 8'h66,
        8'h43, 8'h3C, 8'h32, 8'h34, 8'h2C, 8'h2E, 8'hF5, 8'h5D,
        8'h44, 8'h3B, 8'h2A, 8'h2B, 8'h2D, 8'h25, 8'hF2, 8'h55,
        8'h46, 8'h42, 8'h21, 8'h23, 8'h24, 8'h26, 8'hF4, 8'h4E,
        8'h4D, 8'h3A, 8'h22, 8'h1B, 8'h1D, 8'h1E, 8'hEB, 8'h5B,
        8'h45, 8'h4B, 8'h1A, 8'h1C, 8'h15, 8'h16, 8'h29, 8'h54,
        8'h52, 8'h4C, 8'h41, 8'h04, 8'h14, 8'h0D, 8'h12, 8'h05,
        8'h0E, 8'h4A, 8'h49, 8'h58, 8'h06, 8'h76, 8'h11, 8'h59,
        8'h94, 8'h91
    };

    localparam logic [6:0] seg_ref [16] = '{      // Active low gfedcba
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    z88_kbd_board_top u_dut (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .scan_valid (scan_valid),
        .scan_data  (scan_data),
        .sw         (sw),
        .key_flap_n (key_flap_n),
        .kbd_matrix (kbd_matrix),
        .hex0       (hex0),
        .hex1       (hex1),
        .ledr       (ledr),
        .ledg       (ledg),
        .flap       (flap)
    );

    bind scan_prefix_decoder z88_kbd_board_props u_props (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .scan_valid (scan_valid),
        .scan_data  (scan_data),
        .key_valid  (key_valid)
    );

    initial CLOCK_50 = 1'b0;
    always #2 CLOCK_50 = ~CLOCK_50;

    // ==================================================
    // Helpers
    // ==================================================

    function automatic int bit_of(input int idx);
        if (idx < 64) begin
            return idx;
        end
        return (idx == 64) ? 52 : 62;
    endfunction

    function automatic logic [7:0] columns_or(input logic [63:0] m, input logic [7:0] sel);
        logic [7:0] acc;
        acc = 8'h00;
        for (int c = 0; c < 8; c++) begin
            if (sel[c]) begin
                acc = acc | m[c*8 +: 8];
            end
        end
        return acc;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic abort_run(input string why);
        $display("Timeout at %0t ns: %s", $time, why);
        $display("tests failed");
        $finish;
    endtask

    task automatic test_done(input string name);
        $display("Test %s finished with %0d errors", name, errors - mark);
        mark = errors;
        tests_run++;
    endtask

    task automatic drive_byte(input logic [7:0] b);
        scan_valid = 1'b1;
        scan_data  = b;
        @(negedge CLOCK_50);
        scan_valid = 1'b0;
    endtask

    // Matrix and hex are settled one edge after key_valid
    task automatic wait_key_event();
        int n;
        n = 0;
        while (u_dut.key_valid !== 1'b1) begin
            if (n == 8) begin
                abort_run("no key event after a key code byte");
            end
            @(negedge CLOCK_50);
            n++;
        end
        @(negedge CLOCK_50);
    endtask

    task automatic apply_model(input logic [7:0] code, input logic brk);
        for (int i = 0; i < 66; i++) begin
            if (key_codes[i] == code) begin
                model[bit_of(i)] = ~brk;
            end
        end
    endtask

    task automatic check_hex(input logic [7:0] code);
        if (hex1 !== seg_ref[code[7:4]] || hex0 !== seg_ref[code[3:0]]) begin
            report_mismatch($sformatf("hex %h %h does not show %h", hex1, hex0, code));
        end
    endtask

    task automatic key_cycle(input logic [7:0] code, input logic brk);
        if (code[7]) begin
            drive_byte(8'hE0);
        end
        if (brk) begin
            drive_byte(8'hF0);
        end
        drive_byte({1'b0, code[6:0]});
        wait_key_event();
        apply_model(code, brk);
        if (kbd_matrix !== model) begin
            report_mismatch($sformatf("matrix %h, expected %h after code %h brk %b",
                                      kbd_matrix, model, code, brk));
        end
        check_hex(code);
    endtask

    task automatic wait_ledr(input logic [8:0] exp, input string what);
        int n;
        n = 0;
        while (ledr !== exp && n < 10) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (ledr !== exp) begin
            report_mismatch($sformatf("%s: ledr %h, expected %h", what, ledr, exp));
        end
    endtask

    task automatic hold_ledr(input logic [8:0] exp, input string what);
        for (int n = 0; n < 12; n++) begin
            @(negedge CLOCK_50);
            if (ledr !== exp) begin
                report_mismatch($sformatf("%s: ledr %h, expected %h", what, ledr, exp));
            end
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================

    task automatic test_reset_state();
        if (kbd_matrix !== 64'h0 || ledr !== 9'h000 || flap !== 1'b0) begin
            report_mismatch("outputs not cleared by reset");
        end
        check_hex(8'h00);
        test_done("reset_state");
    endtask

    task automatic test_make_break();
        key_cycle(8'h1C, 1'b0);
        if (kbd_matrix[43] !== 1'b1) begin
            report_mismatch("A make did not set bit 43");
        end
        key_cycle(8'h3E, 1'b0);
        key_cycle(8'h1C, 1'b1);
        test_done("make_break");
    endtask

    task automatic test_extended();
        key_cycle(8'hF5, 1'b0);                   // E0 75
        if (kbd_matrix[14] !== 1'b1) begin
            report_mismatch("Up make did not set bit 14");
        end
        key_cycle(8'hF5, 1'b1);                   // E0 F0 75
        key_cycle(8'h14, 1'b0);
        drive_byte(8'hF0);                        // Break through the 94 alias
        drive_byte(8'h94);
        wait_key_event();
        apply_model(8'h94, 1'b1);
        if (kbd_matrix[52] !== 1'b0 || kbd_matrix !== model) begin
            report_mismatch("code 94 did not clear the Ctrl bit");
        end
        check_hex(8'h94);
        test_done("extended");
    endtask

    task automatic test_unmapped();
        logic [63:0] snap;
        snap = kbd_matrix;
        drive_byte(8'h7E);
        wait_key_event();
        if (kbd_matrix !== snap) begin
            report_mismatch("unmapped code 7E changed the matrix");
        end
        check_hex(8'h7E);
        drive_byte(8'hE0);
        drive_byte(8'hF0);
        for (int n = 0; n < 4; n++) begin
            if (u_dut.key_valid !== 1'b0 || kbd_matrix !== snap) begin
                report_mismatch("prefix bytes alone produced a change");
            end
            @(negedge CLOCK_50);
        end
        check_hex(8'h7E);
        drive_byte(8'h7E);                        // Armed flags make it FE, also unmapped
        wait_key_event();
        if (kbd_matrix !== snap) begin
            report_mismatch("unmapped code FE changed the matrix");
        end
        check_hex(8'hFE);
        test_done("unmapped");
    endtask

    task automatic test_switches();
        sw = 10'h2A5;
        wait_ledr({1'b0, 8'hA5}, "switch level");
        sw = 10'h2A6;                             // SW0 dips, SW1 blips
        repeat (3) @(negedge CLOCK_50);
        sw = 10'h2A5;
        hold_ledr({1'b0, 8'hA5}, "switch glitch");
        test_done("switches");
    endtask

    task automatic test_column_view();
        key_cycle(8'h1C, 1'b0);
        key_cycle(8'hF5, 1'b0);
        key_cycle(8'h76, 1'b0);
        sw = 10'h0A1;                             // A8, A13 and A15
        wait_ledr({1'b0, 8'hA1}, "column select");
        if (ledg !== columns_or(model, 8'hA1)) begin
            report_mismatch($sformatf("ledg %h for columns A1", ledg));
        end
        sw = 10'h002;
        wait_ledr({1'b0, 8'h02}, "column select");
        if (ledg !== columns_or(model, 8'h02)) begin
            report_mismatch($sformatf("ledg %h for column A9", ledg));
        end
        test_done("column_view");
    endtask

    task automatic test_flap();
        logic [8:0] base;
        base = {1'b0, sw[7:0]};
        key_flap_n = 1'b0;
        wait_ledr(base | 9'h100, "flap held");
        if (flap !== 1'b1) begin
            report_mismatch("flap not asserted while held");
        end
        key_flap_n = 1'b1;
        wait_ledr(base, "flap released");
        key_flap_n = 1'b0;
        repeat (3) @(negedge CLOCK_50);
        key_flap_n = 1'b1;
        hold_ledr(base, "flap pulse");
        if (flap !== 1'b0) begin
            report_mismatch("short flap pulse reached flap");
        end
        test_done("flap");
    endtask

    task automatic test_random_keys();
        logic [31:0] r;
        int          idx;
        for (int step = 0; step < 40; step++) begin
            r   = $random(seed);
            idx = int'(r[15:0]) % 66;
            key_cycle(key_codes[idx], r[16]);
        end
        if (ledg !== columns_or(model, sw[7:0])) begin
            report_mismatch($sformatf("ledg %h after random keys", ledg));
        end
        test_done("random_keys");
    endtask

    initial begin
        reset      = 1'b1;
        scan_valid = 1'b0;
        scan_data  = 8'h00;
        sw         = 10'h000;
        key_flap_n = 1'b1;
        model      = 64'h0;
        errors     = 0;
        mark       = 0;
        tests_run  = 0;
        seed       = 32'ha5c01872;
        repeat (5) @(negedge CLOCK_50);
        reset = 1'b0;
        @(negedge CLOCK_50);
        test_reset_state();
        test_make_break();
        test_extended();
        test_unmapped();
        test_switches();
        test_column_view();
        test_flap();
        test_random_keys();
        $display("Summary: %0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/kbd_pkg.sv
rtl/board_pkg.sv
rtl/scan_prefix_decoder.sv
rtl/key_matrix.sv
rtl/switch_filter.sv
rtl/hex_display.sv
rtl/z88_kbd_board_top.sv
verification/z88_kbd_board_props.sv
verification/tb_z88_kbd_board.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_z88_kbd_board
RTL_TOP   ?= z88_kbd_board_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
PASS_TEXT ?= all tests passed
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
